/* Bender.yml */
package:
  name: tcb_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tcb_pkg.sv
      - verilog/tcb_arbiter.sv
      - verilog/tcb_register_response.sv
      - verilog/tcb_memory.sv
      - verilog/tcb_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tcb_top_assertions.sv
      - tests/tcb_top_tb.sv

/* sim.f */
+incdir+verilog
verilog/tcb_pkg.sv
verilog/tcb_arbiter.sv
verilog/tcb_register_response.sv
verilog/tcb_memory.sv
verilog/tcb_top.sv
tests/tcb_top_assertions.sv
tests/tcb_top_tb.sv

/* tests/tcb_top_assertions.sv */
// TCB top-level protocol assertions

`timescale 1ns/10ps

`include "tcb_params.svh"

module tcb_top_assertions (
  input logic man,
  input logic reset,
  input logic m0_vld,
  input logic m0_rdy,
  input logic m0_rsp_vld,
  input logic m1_vld,
  input logic m1_rdy,
  input logic m1_rsp_vld
);

  ////////////////////////////////////////
  // response strobes
  ////////////////////////////////////////

  // one bus response per cycle, one owner
  strobe_onehot: assert property (@(posedge man) disable iff (reset)
    !(m0_rsp_vld && m1_rsp_vld))
    else $error("both response strobes high in the same cycle");

  // transfer to strobe, fixed latency
  m0_latency: assert property (@(posedge man) disable iff (reset)
    (m0_vld && m0_rdy) |-> ##(`TCB_RSP_DLY) m0_rsp_vld)
    else $error("port 0 response strobe not seen two cycles after transfer");

  m1_latency: assert property (@(posedge man) disable iff (reset)
    (m1_vld && m1_rdy) |-> ##(`TCB_RSP_DLY) m1_rsp_vld)
    else $error("port 1 response strobe not seen two cycles after transfer");

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  // an uncontested request is never held off
  m0_alone: assert property (@(posedge man) disable iff (reset)
    (m0_vld && !m1_vld) |-> m0_rdy)
    else $error("port 0 requested alone without rdy");

  m1_alone: assert property (@(posedge man) disable iff (reset)
    (m1_vld && !m0_vld) |-> m1_rdy)
    else $error("port 1 requested alone without rdy");

endmodule

/* tests/tcb_top_tb.sv */
// TCB subsystem testbench

`timescale 1ns/10ps

`include "tcb_params.svh"

module tcb_top_tb;

  import tcb_pkg::*;

  ////////////////////////////////////////
  // types and signals
  ////////////////////////////////////////

  // one stimulus row with its expected response
  typedef struct packed {
    logic                  port;
    logic                  two;
    logic                  wen;
    logic [`TCB_ADR_W-1:0] adr;
    logic [`TCB_BEN_W-1:0] ben;
    tcb_data_u             wdt;
    tcb_data_u             exp_rdt;
    logic                  exp_err;
  } vec_t;

  // pending response and the cycle it is due
  typedef struct packed {
    tcb_data_u   rdt;
    logic        err;
    logic [31:0] due;
  } exp_t;

  // random request pairs
  localparam int NRAND = 40;

  logic                  man = 1'b0;
  logic                  reset;
  logic                  m0_vld;
  logic                  m0_wen;
  logic [`TCB_ADR_W-1:0] m0_adr;
  logic [`TCB_BEN_W-1:0] m0_ben;
  tcb_data_u             m0_wdt;
  logic                  m0_rdy;
  logic                  m0_rsp_vld;
  tcb_data_u             m0_rdt;
  logic                  m0_err;
  logic                  m1_vld;
  logic                  m1_wen;
  logic [`TCB_ADR_W-1:0] m1_adr;
  logic [`TCB_BEN_W-1:0] m1_ben;
  tcb_data_u             m1_wdt;
  logic                  m1_rdy;
  logic                  m1_rsp_vld;
  tcb_data_u             m1_rdt;
  logic                  m1_err;

  vec_t vecs[$];
  // per-port responses in request order
  exp_t q0[$];
  exp_t q1[$];
  // reference memory, one entry per byte address
  logic [7:0] ref_mem [0:`TCB_MEM_DEPTH*`TCB_BEN_W-1];
  // manager that wins the next contested cycle
  logic next_owner;
  // table row behind the current request, -1 for random
  int vec_idx0 = -1;
  int vec_idx1 = -1;
  int cycle = 0;
  int cycle_limit = 1000;
  int data_errs = 0;
  int err_errs = 0;
  int rdy_errs = 0;
  int proto_errs = 0;
  logic [31:0] seed;

  ////////////////////////////////////////
  // DUT, clock, timeout
  ////////////////////////////////////////

  tcb_top UUT (
    .man        (man),
    .reset      (reset),
    .m0_vld     (m0_vld),
    .m0_wen     (m0_wen),
    .m0_adr     (m0_adr),
    .m0_ben     (m0_ben),
    .m0_wdt     (m0_wdt),
    .m0_rdy     (m0_rdy),
    .m0_rsp_vld (m0_rsp_vld),
    .m0_rdt     (m0_rdt),
    .m0_err     (m0_err),
    .m1_vld     (m1_vld),
    .m1_wen     (m1_wen),
    .m1_adr     (m1_adr),
    .m1_ben     (m1_ben),
    .m1_wdt     (m1_wdt),
    .m1_rdy     (m1_rdy),
    .m1_rsp_vld (m1_rsp_vld),
    .m1_rdt     (m1_rdt),
    .m1_err     (m1_err)
  );

  bind tcb_top tcb_top_assertions chk (
    .man        (man),
    .reset      (reset),
    .m0_vld     (m0_vld),
    .m0_rdy     (m0_rdy),
    .m0_rsp_vld (m0_rsp_vld),
    .m1_vld     (m1_vld),
    .m1_rdy     (m1_rdy),
    .m1_rsp_vld (m1_rsp_vld)
  );

  // 4 ns period
  always #2 man = ~man;

  always @(posedge man)
  begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit)
    begin
      $display("Error: run stopped at cycle %0d, responses still outstanding", cycle);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // old word out, enabled bytes in
  task automatic model_access(input logic wen, input logic [`TCB_ADR_W-1:0] adr,
                              input logic [`TCB_BEN_W-1:0] ben, input tcb_data_u wdt,
                              output tcb_data_u rdt, output logic err);
    int widx;
    int i;
    widx = adr / `TCB_BEN_W;
    rdt = '0;
    err = (widx >= `TCB_MEM_DEPTH);
    if (!err)
    begin
      for (i = 0; i < `TCB_BEN_W; i++)
      begin
        rdt.bytes[i] = ref_mem[widx*`TCB_BEN_W + i];
        if (wen && ben[i])
        begin
          ref_mem[widx*`TCB_BEN_W + i] = wdt.bytes[i];
        end
      end
    end
  endtask

  task automatic check_data(input string name, input tcb_data_u got, input tcb_data_u exp);
    if (got !== exp)
    begin
      data_errs++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got.word, exp.word);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_errs++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_rdy(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      rdy_errs++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // round robin, a contested cycle goes to next_owner and then turns over
  task automatic check_grant();
    logic exp0;
    logic exp1;
    if (m0_vld && m1_vld)
    begin
      exp0 = (next_owner == 1'b0);
      exp1 = (next_owner == 1'b1);
      next_owner = ~next_owner;
    end
    else
    begin
      // held off only by the other port's request
      exp0 = !m1_vld;
      exp1 = !m0_vld;
    end
    check_rdy("m0_rdy", m0_rdy, exp0);
    check_rdy("m1_rdy", m1_rdy, exp1);
  endtask

  // strobe against the head of the port's queue
  task automatic check_response(input int p, input logic strobe, input tcb_data_u rdt,
                                input logic err);
    exp_t e;
    logic have;
    have = (p == 0) ? (q0.size() > 0) : (q1.size() > 0);
    if (have)
    begin
      e = (p == 0) ? q0[0] : q1[0];
    end
    if (strobe && !have)
    begin
      proto_errs++;
      $display("Error at %0t: response on port %0d with no transfer pending", $time, p);
    end
    else if (strobe)
    begin
      if (e.due != cycle)
      begin
        proto_errs++;
        $display("Error at %0t: port %0d response in cycle %0d, due in cycle %0d",
                 $time, p, cycle, e.due);
      end
      check_data($sformatf("m%0d_rdt", p), rdt, e.rdt);
      check_err($sformatf("m%0d_err", p), err, e.err);
    end
    else if (have && e.due <= cycle)
    begin
      proto_errs++;
      $display("Error at %0t: port %0d response missing in cycle %0d", $time, p, e.due);
    end
    if (have && (strobe || e.due <= cycle))
    begin
      if (p == 0)
      begin
        void'(q0.pop_front());
      end
      else
      begin
        void'(q1.pop_front());
      end
    end
  endtask

  // accepted request, model updated in transfer order
  task automatic record_transfer(input int p, input logic wen,
                                 input logic [`TCB_ADR_W-1:0] adr,
                                 input logic [`TCB_BEN_W-1:0] ben,
                                 input tcb_data_u wdt, input int idx);
    exp_t e;
    tcb_data_u rdt;
    logic err;
    model_access(wen, adr, ben, wdt, rdt, err);
    if (idx >= 0)
    begin
      check_data($sformatf("table[%0d] rdt", idx), vecs[idx].exp_rdt, rdt);
      check_err($sformatf("table[%0d] err", idx), vecs[idx].exp_err, err);
    end
    e.rdt = rdt;
    e.err = err;
    e.due = cycle + `TCB_RSP_DLY;
    if (p == 0)
    begin
      q0.push_back(e);
    end
    else
    begin
      q1.push_back(e);
    end
  endtask

  // mid-cycle, inputs and rdy are settled
  always @(negedge man)
  begin
    if (reset)
    begin
      next_owner = 1'b0;
    end
    else
    begin
      check_grant();
      check_response(0, m0_rsp_vld, m0_rdt, m0_err);
      check_response(1, m1_rsp_vld, m1_rdt, m1_err);
      if (m0_vld && m0_rdy)
      begin
        record_transfer(0, m0_wen, m0_adr, m0_ben, m0_wdt, vec_idx0);
      end
      if (m1_vld && m1_rdy)
      begin
        record_transfer(1, m1_wen, m1_adr, m1_ben, m1_wdt, vec_idx1);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic add_vec(input logic port, input logic two, input logic wen,
                         input logic [`TCB_ADR_W-1:0] adr, input logic [`TCB_BEN_W-1:0] ben,
                         input logic [31:0] wdt, input logic [31:0] exp_rdt,
                         input logic exp_err);
    vec_t v;
    v.port = port;
    v.two = two;
    v.wen = wen;
    v.adr = adr;
    v.ben = ben;
    v.wdt.word = wdt;
    v.exp_rdt.word = exp_rdt;
    v.exp_err = exp_err;
    vecs.push_back(v);
  endtask

  task automatic load_table();
    // full word write, read back, overwrite
    add_vec(0, 0, 1, 'h010, 'hf, 32'ha5a5_1234, 32'hxxxx_xxxx, 0);
    add_vec(0, 0, 0, 'h010, 'hf, 32'h0, 32'ha5a5_1234, 0);
    add_vec(0, 0, 1, 'h010, 'hf, 32'h0bad_f00d, 32'ha5a5_1234, 0);
    // lanes 0 and 2, then lane 3 from the other port
    add_vec(0, 0, 1, 'h010, 'h5, 32'h1122_3344, 32'h0bad_f00d, 0);
    add_vec(1, 0, 0, 'h010, 'hf, 32'h0, 32'h0b22_f044, 0);
    add_vec(1, 0, 1, 'h010, 'h8, 32'hee00_0000, 32'h0b22_f044, 0);
    add_vec(1, 0, 0, 'h010, 'hf, 32'h0, 32'hee22_f044, 0);
    // out of range, 0x400 aliases word 0 in the low bits
    add_vec(0, 0, 1, 'h000, 'hf, 32'h600d_0000, 32'hxxxx_xxxx, 0);
    add_vec(0, 0, 1, 'h400, 'hf, 32'hdead_beef, 32'h0, 1);
    add_vec(0, 0, 0, 'hffc, 'hf, 32'h0, 32'h0, 1);
    add_vec(0, 0, 0, 'h000, 'hf, 32'h0, 32'h600d_0000, 0);
    // both ports in the same cycles
    add_vec(0, 1, 1, 'h020, 'hf, 32'h0000_aaaa, 32'hxxxx_xxxx, 0);
    add_vec(1, 0, 1, 'h024, 'hf, 32'h0000_bbbb, 32'hxxxx_xxxx, 0);
    add_vec(0, 1, 0, 'h024, 'hf, 32'h0, 32'h0000_bbbb, 0);
    add_vec(1, 0, 0, 'h020, 'hf, 32'h0, 32'h0000_aaaa, 0);
    add_vec(0, 1, 1, 'h020, 'hf, 32'h1234_5678, 32'h0000_aaaa, 0);
    add_vec(1, 0, 1, 'h024, 'hf, 32'h9abc_def0, 32'h0000_bbbb, 0);
    // back to back on port 1
    add_vec(1, 0, 0, 'h020, 'hf, 32'h0, 32'h1234_5678, 0);
    add_vec(1, 0, 0, 'h024, 'hf, 32'h0, 32'h9abc_def0, 0);
    add_vec(1, 0, 0, 'h010, 'hf, 32'h0, 32'hee22_f044, 0);
  endtask

  // mostly a small window, sometimes past the end
  task automatic rand_vec(output vec_t v);
    logic [9:0] widx;
    seed = lcg_next(seed);
    widx = {5'd0, seed[20:16]};
    if (seed[31:29] == 3'b111)
    begin
      widx = {2'b01, seed[28:21]};
    end
    v = '0;
    v.wen = seed[25];
    v.ben = seed[15:12];
    v.adr = {widx, seed[23:22]};
    seed = lcg_next(seed);
    v.wdt.word = seed;
  endtask

  // drives one or both ports, returns 1 ns after the last acceptance
  task automatic issue(input logic v0, input vec_t r0, input int i0,
                       input logic v1, input vec_t r1, input int i1);
    logic done0;
    logic done1;
    vec_idx0 = i0;
    vec_idx1 = i1;
    m0_vld = v0;
    m0_wen = r0.wen;
    m0_adr = r0.adr;
    m0_ben = r0.ben;
    m0_wdt = r0.wdt;
    m1_vld = v1;
    m1_wen = r1.wen;
    m1_adr = r1.adr;
    m1_ben = r1.ben;
    m1_wdt = r1.wdt;
    done0 = ~v0;
    done1 = ~v1;
    while (!(done0 && done1))
    begin
      @(negedge man);
      if (m0_vld && m0_rdy)
      begin
        done0 = 1'b1;
      end
      if (m1_vld && m1_rdy)
      begin
        done1 = 1'b1;
      end
      @(posedge man);
      #1;
      if (done0)
      begin
        m0_vld = 1'b0;
      end
      if (done1)
      begin
        m1_vld = 1'b0;
      end
    end
  endtask

  initial
  begin
    int i;
    int n;
    vec_t a;
    vec_t b;
    reset = 1'b1;
    m0_vld = 1'b0;
    m0_wen = 1'b0;
    m0_adr = '0;
    m0_ben = '0;
    m0_wdt = '0;
    m1_vld = 1'b0;
    m1_wen = 1'b0;
    m1_adr = '0;
    m1_ben = '0;
    m1_wdt = '0;
    seed = 32'h30d1512e;
    // memory content unknown until written
    for (i = 0; i < `TCB_MEM_DEPTH*`TCB_BEN_W; i++)
    begin
      ref_mem[i] = 'x;
    end
    load_table();
    cycle_limit = 2 * (vecs.size() + 2 * NRAND) + 50;
    repeat (2) @(posedge man);
    #1;
    reset = 1'b0;

    // table pass, paired rows go out together
    i = 0;
    while (i < vecs.size())
    begin
      a = vecs[i];
      if (a.two)
      begin
        b = vecs[i+1];
        issue(1'b1, a, i, 1'b1, b, i + 1);
        i += 2;
      end
      else
      begin
        if (a.port == 1'b0)
        begin
          issue(1'b1, a, i, 1'b0, a, -1);
        end
        else
        begin
          issue(1'b0, a, -1, 1'b1, a, i);
        end
        i++;
      end
    end

    // random traffic on both ports
    for (n = 0; n < NRAND; n++)
    begin
      rand_vec(a);
      rand_vec(b);
      issue(1'b1, a, -1, 1'b1, b, -1);
    end

    while (q0.size() != 0 || q1.size() != 0)
    begin
      @(posedge man);
    end
    repeat (2) @(posedge man);
    $display("errors: data %0d, err %0d, rdy %0d, protocol %0d",
             data_errs, err_errs, rdy_errs, proto_errs);
    if (data_errs + err_errs + rdy_errs + proto_errs == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog/tcb_arbiter.sv */
// TCB two-port round-robin arbiter

`timescale 1ns/10ps

`include "tcb_params.svh"

module tcb_arbiter (
  input  logic                   man,
  input  logic                   reset,
  // manager 0 request
  input  logic                   m0_vld,
  input  logic                   m0_wen,
  input  logic [`TCB_ADR_W-1:0]  m0_adr,
  input  logic [`TCB_BEN_W-1:0]  m0_ben,
  input  tcb_pkg::tcb_data_u     m0_wdt,
  // manager 1 request
  input  logic                   m1_vld,
  input  logic                   m1_wen,
  input  logic [`TCB_ADR_W-1:0]  m1_adr,
  input  logic [`TCB_BEN_W-1:0]  m1_ben,
  input  tcb_pkg::tcb_data_u     m1_wdt,
  // manager handshake and response
  output logic                   m0_rdy,
  output logic                   m1_rdy,
  output logic                   m0_rsp_vld,
  output logic                   m1_rsp_vld,
  output tcb_pkg::tcb_data_u     m0_rdt,
  output tcb_pkg::tcb_data_u     m1_rdt,
  output logic                   m0_err,
  output logic                   m1_err,
  // shared bus request
  output logic                   bus_vld,
  output logic                   bus_wen,
  output logic [`TCB_ADR_W-1:0]  bus_adr,
  output logic [`TCB_BEN_W-1:0]  bus_ben,
  output tcb_pkg::tcb_data_u     bus_wdt,
  // shared bus response, TCB_RSP_DLY after transfer
  input  tcb_pkg::tcb_data_u     bus_rdt,
  input  logic                   bus_err
);

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  // priority bit, 0 favours manager 0
  logic pri;
  logic gnt0;
  logic gnt1;

  // manager 0 wins when alone or when it holds priority
  assign gnt0 = m0_vld & (~m1_vld | ~pri);
  // manager 1 likewise
  assign gnt1 = m1_vld & (~m0_vld | pri);

  // only the other port's grant holds a manager off
  assign m0_rdy = ~gnt1;
  assign m1_rdy = ~gnt0;

  // priority moves to the loser after a contested cycle
  always_ff @(posedge man)
  begin
    if (reset)
    begin
      pri <= 1'b0;
    end
    else if (m0_vld & m1_vld)
    begin
      pri <= gnt0;
    end
  end

  ////////////////////////////////////////
  // request mux
  ////////////////////////////////////////

  // any request is granted, so any vld is a transfer
  assign bus_vld = gnt0 | gnt1;
  // gnt1 selects manager 1
  assign bus_wen = gnt1 ? m1_wen : m0_wen;
  assign bus_adr = gnt1 ? m1_adr : m0_adr;
  assign bus_ben = gnt1 ? m1_ben : m0_ben;
  assign bus_wdt = gnt1 ? m1_wdt : m0_wdt;

  ////////////////////////////////////////
  // response owner pipeline
  ////////////////////////////////////////

  // one entry per cycle of response delay
  logic [`TCB_RSP_DLY-1:0] pipe_vld;
  // owner of each entry, 1 for manager 1
  logic [`TCB_RSP_DLY-1:0] pipe_own;

  always_ff @(posedge man)
  begin
    if (reset)
    begin
      pipe_vld <= '0;
      pipe_own <= '0;
    end
    else
    begin
      pipe_vld <= {pipe_vld[`TCB_RSP_DLY-2:0], bus_vld};
      pipe_own <= {pipe_own[`TCB_RSP_DLY-2:0], gnt1};
    end
  end

  // last entry lines up with the bus response
  assign m0_rsp_vld = pipe_vld[`TCB_RSP_DLY-1] & ~pipe_own[`TCB_RSP_DLY-1];
  assign m1_rsp_vld = pipe_vld[`TCB_RSP_DLY-1] &  pipe_own[`TCB_RSP_DLY-1];

  // data fans out, strobes qualify it
  assign m0_rdt = bus_rdt;
  assign m1_rdt = bus_rdt;
  assign m0_err = bus_err;
  assign m1_err = bus_err;

endmodule

/* verilog/tcb_memory.sv */
// TCB synchronous memory

`timescale 1ns/10ps

`include "tcb_params.svh"

module tcb_memory #(
  parameter int DEPTH = `TCB_MEM_DEPTH
) (
  input  logic                   man,
  input  logic                   reset,
  // request, every vld cycle is a transfer
  input  logic                   vld,
  input  logic                   wen,
  input  logic [`TCB_ADR_W-1:0]  adr,
  input  logic [`TCB_BEN_W-1:0]  ben,
  input  tcb_pkg::tcb_data_u     wdt,
  // response, one cycle after transfer
  output tcb_pkg::tcb_data_u     rdt,
  output logic                   err
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  // byte offset bits within a word
  localparam int OFS_W = $clog2(`TCB_BEN_W);
  // bits needed to index the array
  localparam int IDX_W = $clog2(DEPTH);

  // word index from byte address
  logic [`TCB_ADR_W-OFS_W-1:0] idx;
  // array index, valid only in range
  logic [IDX_W-1:0] mi;
  logic in_range;

  assign idx = adr[`TCB_ADR_W-1:OFS_W];
  assign mi = idx[IDX_W-1:0];
  // words at or past DEPTH are errors
  assign in_range = (idx < DEPTH);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  tcb_data_u mem [0:DEPTH-1];

  // lane-masked write through the byte view
  always_ff @(posedge man)
  begin
    if (vld & wen & in_range)
    begin
      for (int i = 0; i < `TCB_BEN_W; i++)
      begin
        if (ben[i])
        begin
          mem[mi].bytes[i] <= wdt.bytes[i];
        end
      end
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // old word on every transfer, also for writes
  always_ff @(posedge man)
  begin
    if (vld)
    begin
      rdt.word <= in_range ? mem[mi].word : '0;
    end
  end

  // error status
  always_ff @(posedge man)
  begin
    if (reset)
    begin
      err <= 1'b0;
    end
    else if (vld)
    begin
      err <= ~in_range;
    end
  end

endmodule

/* verilog/tcb_params.svh */
// TCB bus parameters

`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

// byte address width
`define TCB_ADR_W 12

// data width and byte lanes
`define TCB_DAT_W 32
`define TCB_BEN_W 4

// memory size in words, 1024 bytes
`define TCB_MEM_DEPTH 256

// memory response delay in cycles
`define TCB_MEM_DLY 1
// delay seen at the arbiter, memory plus one slice stage
`define TCB_RSP_DLY (`TCB_MEM_DLY + 1)

`endif

/* verilog/tcb_pkg.sv */
// TCB shared types

`include "tcb_params.svh"

package tcb_pkg;

  ////////////////////////////////////////
  // data word
  ////////////////////////////////////////

  // one bus word with two decodings
  // word view for whole reads
  // byte view for lane-masked writes
  typedef union packed {
    logic [`TCB_DAT_W-1:0] word;
    logic [`TCB_BEN_W-1:0][7:0] bytes;
  } tcb_data_u;

  // lane 0 holds the lowest byte address
  // both views are the same width

endpackage

/* verilog/tcb_register_response.sv */
// TCB response register slice

`timescale 1ns/10ps

`include "tcb_params.svh"

module tcb_register_response (
  input  logic                   man,
  // subordinate side, toward the arbiter
  input  logic                   sub_vld,
  input  logic                   sub_wen,
  input  logic [`TCB_ADR_W-1:0]  sub_adr,
  input  logic [`TCB_BEN_W-1:0]  sub_ben,
  input  tcb_pkg::tcb_data_u     sub_wdt,
  output tcb_pkg::tcb_data_u     sub_rdt,
  output logic                   sub_err,
  // manager side, toward the memory
  output logic                   man_vld,
  output logic                   man_wen,
  output logic [`TCB_ADR_W-1:0]  man_adr,
  output logic [`TCB_BEN_W-1:0]  man_ben,
  output tcb_pkg::tcb_data_u     man_wdt,
  input  tcb_pkg::tcb_data_u     man_rdt,
  input  logic                   man_err
);

  ////////////////////////////////////////
  // request, zero cycles
  ////////////////////////////////////////

  assign man_vld = sub_vld;
  assign man_wen = sub_wen;
  assign man_adr = sub_adr;
  assign man_ben = sub_ben;
  assign man_wdt = sub_wdt;

  ////////////////////////////////////////
  // response, one cycle
  ////////////////////////////////////////

  // whole response sampled every edge
  always_ff @(posedge man)
  begin
    sub_rdt <= man_rdt;
    sub_err <= man_err;
  end

endmodule

/* verilog/tcb_top.sv */
// TCB two-manager subsystem

`timescale 1ns/10ps

`include "tcb_params.svh"

module tcb_top (
  input  logic                   man,
  input  logic                   reset,
  // manager 0
  input  logic                   m0_vld,
  input  logic                   m0_wen,
  input  logic [`TCB_ADR_W-1:0]  m0_adr,
  input  logic [`TCB_BEN_W-1:0]  m0_ben,
  input  tcb_pkg::tcb_data_u     m0_wdt,
  output logic                   m0_rdy,
  output logic                   m0_rsp_vld,
  output tcb_pkg::tcb_data_u     m0_rdt,
  output logic                   m0_err,
  // manager 1
  input  logic                   m1_vld,
  input  logic                   m1_wen,
  input  logic [`TCB_ADR_W-1:0]  m1_adr,
  input  logic [`TCB_BEN_W-1:0]  m1_ben,
  input  tcb_pkg::tcb_data_u     m1_wdt,
  output logic                   m1_rdy,
  output logic                   m1_rsp_vld,
  output tcb_pkg::tcb_data_u     m1_rdt,
  output logic                   m1_err
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // shared bus wires
  ////////////////////////////////////////

  // arbiter side, response two cycles after transfer
  logic                  bus_vld;
  logic                  bus_wen;
  logic [`TCB_ADR_W-1:0] bus_adr;
  logic [`TCB_BEN_W-1:0] bus_ben;
  tcb_data_u             bus_wdt;
  tcb_data_u             bus_rdt;
  logic                  bus_err;

  // memory side, response one cycle after transfer
  logic                  mem_vld;
  logic                  mem_wen;
  logic [`TCB_ADR_W-1:0] mem_adr;
  logic [`TCB_BEN_W-1:0] mem_ben;
  tcb_data_u             mem_wdt;
  tcb_data_u             mem_rdt;
  logic                  mem_err;

  ////////////////////////////////////////
  // arbiter
  ////////////////////////////////////////

  tcb_arbiter arb (
    .man        (man),
    .reset      (reset),
    .m0_vld     (m0_vld),
    .m0_wen     (m0_wen),
    .m0_adr     (m0_adr),
    .m0_ben     (m0_ben),
    .m0_wdt     (m0_wdt),
    .m1_vld     (m1_vld),
    .m1_wen     (m1_wen),
    .m1_adr     (m1_adr),
    .m1_ben     (m1_ben),
    .m1_wdt     (m1_wdt),
    .m0_rdy     (m0_rdy),
    .m1_rdy     (m1_rdy),
    .m0_rsp_vld (m0_rsp_vld),
    .m1_rsp_vld (m1_rsp_vld),
    .m0_rdt     (m0_rdt),
    .m1_rdt     (m1_rdt),
    .m0_err     (m0_err),
    .m1_err     (m1_err),
    .bus_vld    (bus_vld),
    .bus_wen    (bus_wen),
    .bus_adr    (bus_adr),
    .bus_ben    (bus_ben),
    .bus_wdt    (bus_wdt),
    .bus_rdt    (bus_rdt),
    .bus_err    (bus_err)
  );

  ////////////////////////////////////////
  // response slice
  ////////////////////////////////////////

  tcb_register_response slice (
    .man     (man),
    .sub_vld (bus_vld),
    .sub_wen (bus_wen),
    .sub_adr (bus_adr),
    .sub_ben (bus_ben),
    .sub_wdt (bus_wdt),
    .sub_rdt (bus_rdt),
    .sub_err (bus_err),
    .man_vld (mem_vld),
    .man_wen (mem_wen),
    .man_adr (mem_adr),
    .man_ben (mem_ben),
    .man_wdt (mem_wdt),
    .man_rdt (mem_rdt),
    .man_err (mem_err)
  );

  ////////////////////////////////////////
  // memory
  ////////////////////////////////////////

  tcb_memory #(
    .DEPTH (`TCB_MEM_DEPTH)
  ) mem (
    .man   (man),
    .reset (reset),
    .vld   (mem_vld),
    .wen   (mem_wen),
    .adr   (mem_adr),
    .ben   (mem_ben),
    .wdt   (mem_wdt),
    .rdt   (mem_rdt),
    .err   (mem_err)
  );

endmodule
